// ==== common/uart_cfg.svh ====
// ------------------------------
// Build-time settings for the
// dual-channel serial receiver
// ------------------------------
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Data bits per frame sent LSB first
`define UART_DATA_LEN 8
// Clock cycles per serial bit (clk frequency / baud rate)
// Kept small for simulation and raised for a real baud rate
`define UART_CLKS_PER_BIT 16
// Number of serial lines merged into the output stream
`define UART_CHANNELS 2

`endif

// ==== common/uart_pkg.sv ====
// ------------------------------
// Shared types for the receivers
// and the merge block
// ------------------------------
`include "uart_cfg.svh"

package uart_pkg;

	// One received data word
	typedef logic [`UART_DATA_LEN-1:0] rx_byte_t;

	// Index of the serial line a byte came from
	// 0 is line a, 1 is line b
	typedef logic chan_t;

endpackage

// ==== rtl/dual_uart_rx.sv ====
// ------------------------------
// Top level with two serial
// receivers feeding one merge
// ------------------------------
`timescale 1ns/1ps

module dual_uart_rx (
	input  logic               clk,
	input  logic               reset,
	input  logic               rx_a,
	input  logic               rx_b,
	output logic               byte_valid,
	output uart_pkg::rx_byte_t byte_data,
	output uart_pkg::chan_t    byte_chan
);

	// Receiver a results
	logic               receive_a;
	uart_pkg::rx_byte_t data_a;

	// Receiver b results
	logic               receive_b;
	uart_pkg::rx_byte_t data_b;

	// Receiver on line a reports as channel 0
	uart_rx u_rx_a (
		.clk         (clk),
		.reset       (reset),
		.rx_data     (rx_a),
		.receive_sig (receive_a),
		.data        (data_a)
	);

	// Receiver on line b reports as channel 1
	uart_rx u_rx_b (
		.clk         (clk),
		.reset       (reset),
		.rx_data     (rx_b),
		.receive_sig (receive_b),
		.data        (data_b)
	);

	// Combine both byte streams with channel 0 first on a tie
	rx_merge u_merge (
		.clk        (clk),
		.reset      (reset),
		.receive_a  (receive_a),
		.data_a     (data_a),
		.receive_b  (receive_b),
		.data_b     (data_b),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_chan  (byte_chan)
	);

endmodule

// ==== rtl/rx_merge.sv ====
// ------------------------------
// Merges the receivers' byte
// strobes into one tagged stream
// with priority for channel 0
// ------------------------------
`timescale 1ns/1ps
`include "uart_cfg.svh"

module rx_merge (
	input  logic               clk,
	input  logic               reset,
	input  logic               receive_a,
	input  uart_pkg::rx_byte_t data_a,
	input  logic               receive_b,
	input  uart_pkg::rx_byte_t data_b,
	output logic               byte_valid,
	output uart_pkg::rx_byte_t byte_data,
	output uart_pkg::chan_t    byte_chan
);

	// Per-channel views of the loose input ports
	logic [`UART_CHANNELS-1:0] pulse;
	uart_pkg::rx_byte_t        in_byte [`UART_CHANNELS];

	// Bytes waiting for their turn on the output
	logic [`UART_CHANNELS-1:0] pending;
	uart_pkg::rx_byte_t        held [`UART_CHANNELS];

	// Channels wanting the output this cycle and the one granted
	logic [`UART_CHANNELS-1:0] request;
	logic [`UART_CHANNELS-1:0] grant;
	logic                      sel_found;
	uart_pkg::chan_t           sel_chan;
	uart_pkg::rx_byte_t        sel_data;

	// Line a is channel 0, line b is channel 1
	assign pulse      = {receive_b, receive_a};
	assign in_byte[0] = data_a;
	assign in_byte[1] = data_b;

	// A fresh pulse competes in the same cycle it arrives
	assign request = pulse | pending;

	// Fixed priority where the lowest channel number wins
	always_comb
	begin
		sel_found = 1'b0;
		sel_chan  = '0;
		grant     = '0;
		for (int i = `UART_CHANNELS - 1; i >= 0; i--)
		begin
			if (request[i])
			begin
				sel_found = 1'b1;
				sel_chan  = uart_pkg::chan_t'(i);
			end
		end
		if (sel_found)
		begin
			grant[sel_chan] = 1'b1;
		end
	end

	// A waiting byte comes from its holding register
	// and a fresh one straight from the receiver port
	assign sel_data = pending[sel_chan] ? held[sel_chan] : in_byte[sel_chan];

	// A pulse that loses arbitration leaves its pending flag set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending <= '0;
		end
		else
		begin
			pending <= request & ~grant;
		end
	end

	// Holding registers capture on each channel's own pulse
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `UART_CHANNELS; i++)
		begin
			if (pulse[i])
			begin
				held[i] <= in_byte[i];
			end
		end
	end

	// One-cycle output strobe for each granted byte
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= sel_found;
		end
	end

	// Data and tag keep their last values between strobes
	always_ff @(posedge clk)
	begin
		if (sel_found)
		begin
			byte_data <= sel_data;
			byte_chan <= sel_chan;
		end
	end

endmodule

// ==== sources.f ====
+incdir+common
+incdir+testbench
common/uart_pkg.sv
uart_rx/uart_rx.sv
rtl/rx_merge.sv
rtl/dual_uart_rx.sv
testbench/tb_dual_uart_rx.sv

// ==== testbench/uart_tb_tasks.svh ====
// ------------------------------
// Testbench helpers
// Serial line drivers for frames
// and glitches, LFSR number source
// ------------------------------
`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// Put one level on a line and hold it for a full bit period
task automatic drive_bit(input int chan, input logic level);
	@(posedge clk);
	if (chan == 0)
	begin
		rx_a <= level;
	end
	else
	begin
		rx_b <= level;
	end
	repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
endtask

// Start bit, data LSB first, then stop bit
// A bad stop bit is driven low and then the line is released for a bit
task automatic send_frame(input int chan, input uart_pkg::rx_byte_t value, input bit bad_stop);
	drive_bit(chan, 1'b0);
	for (int i = 0; i < `UART_DATA_LEN; i++)
	begin
		drive_bit(chan, value[i]);
	end
	drive_bit(chan, !bad_stop);
	if (bad_stop)
	begin
		drive_bit(chan, 1'b1);
	end
endtask

// Short low pulse followed by one idle bit period
task automatic send_glitch(input int chan, input int low_cycles);
	@(posedge clk);
	if (chan == 0)
	begin
		rx_a <= 1'b0;
	end
	else
	begin
		rx_b <= 1'b0;
	end
	repeat (low_cycles - 1) @(posedge clk);
	drive_bit(chan, 1'b1);
endtask

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic [31:0] n;
	n = s >> 1;
	if (s[0])
	begin
		n = n ^ 32'h8020_0003;
	end
	return n;
endfunction

// One LFSR step per bit taken and the first bit ends up as the MSB
function automatic int unsigned rand_bits(input int count);
	int unsigned v;
	v = 0;
	for (int i = 0; i < count; i++)
	begin
		lfsr_state = lfsr_step(lfsr_state);
		v = (v << 1) | lfsr_state[0];
	end
	return v;
endfunction

`endif

// ==== testbench/tb_dual_uart_rx.sv ====
// ------------------------------
// Testbench for the dual receiver
// Clock, reset, watchdog, monitor
// and directed tests
// ------------------------------
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_dual_uart_rx;

	localparam int CLK_PERIOD = 4;
	// Frames per test with the glitch counted as a frame
	// 1 + 1 + 2 + 2 + 2 + 40
	localparam int TEST_FRAMES = 48;
	localparam int WATCHDOG_NS = 2 * TEST_FRAMES * 11 * `UART_CLKS_PER_BIT * CLK_PERIOD;
	localparam int STREAM_LEN = 20;

	logic               clk;
	logic               reset;
	logic               rx_a;
	logic               rx_b;
	logic               byte_valid;
	uart_pkg::rx_byte_t byte_data;
	uart_pkg::chan_t    byte_chan;

	// Bytes seen at the output and bytes the current test expects
	uart_pkg::chan_t    got_chan[$];
	uart_pkg::rx_byte_t got_data[$];
	uart_pkg::chan_t    exp_chan[$];
	uart_pkg::rx_byte_t exp_data[$];

	int          error_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	logic [31:0] lfsr_state = 32'hb88eae88;

	`include "uart_tb_tasks.svh"

	dual_uart_rx u_dual_uart_rx (
		.clk        (clk),
		.reset      (reset),
		.rx_a       (rx_a),
		.rx_b       (rx_b),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_chan  (byte_chan)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Ends a run that stops making progress
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

	// Collect every output strobe
	always @(posedge clk)
	begin
		if (byte_valid === 1'b1)
		begin
			got_chan.push_back(byte_chan);
			got_data.push_back(byte_data);
		end
	end

	task automatic expect_byte(input int chan, input uart_pkg::rx_byte_t value);
		exp_chan.push_back(uart_pkg::chan_t'(chan));
		exp_data.push_back(value);
	endtask

	// Wait a bounded time for the expected count and then leave room for extra bytes
	task automatic wait_for_bytes();
		int cycles;
		cycles = 0;
		while (got_data.size() < exp_data.size() && cycles < 4 * `UART_CLKS_PER_BIT)
		begin
			@(posedge clk);
			cycles++;
		end
		repeat (2 * `UART_CLKS_PER_BIT) @(posedge clk);
	endtask

	// Whole output sequence against the expected list including order
	task automatic compare_order(input string name);
		int n;
		n = (got_data.size() < exp_data.size()) ? got_data.size() : exp_data.size();
		for (int i = 0; i < n; i++)
		begin
			if (got_chan[i] !== exp_chan[i] || got_data[i] !== exp_data[i])
			begin
				$display("Mismatch at %0t: %s byte %0d expected ch%0d %02h, got ch%0d %02h",
					$time, name, i, exp_chan[i], exp_data[i], got_chan[i], got_data[i]);
				error_count++;
			end
		end
		for (int i = n; i < exp_data.size(); i++)
		begin
			$display("%s: byte %0d on channel %0d never arrived", name, i, exp_chan[i]);
			error_count++;
		end
		for (int i = n; i < got_data.size(); i++)
		begin
			$display("%s: extra byte %02h arrived on channel %0d", name, got_data[i], got_chan[i]);
			error_count++;
		end
	endtask

	// One channel's bytes only since interleaving between channels is free
	task automatic compare_channel(input string name, input int chan);
		uart_pkg::rx_byte_t got_q[$];
		uart_pkg::rx_byte_t exp_q[$];
		int n;
		foreach (got_data[i])
		begin
			if (got_chan[i] == chan)
			begin
				got_q.push_back(got_data[i]);
			end
		end
		foreach (exp_data[i])
		begin
			if (exp_chan[i] == chan)
			begin
				exp_q.push_back(exp_data[i]);
			end
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
		begin
			if (got_q[i] !== exp_q[i])
			begin
				$display("Mismatch at %0t: %s channel %0d byte %0d expected %02h, got %02h",
					$time, name, chan, i, exp_q[i], got_q[i]);
				error_count++;
			end
		end
		if (got_q.size() != exp_q.size())
		begin
			$display("%s: channel %0d delivered %0d bytes instead of %0d",
				name, chan, got_q.size(), exp_q.size());
			error_count++;
		end
	endtask

	// Wait, compare, report one line for the test, then reset the lists
	task automatic check_result(input string name, input bit per_channel);
		int errors_before;
		errors_before = error_count;
		wait_for_bytes();
		if (per_channel)
		begin
			compare_channel(name, 0);
			compare_channel(name, 1);
		end
		else
		begin
			compare_order(name);
		end
		if (error_count == errors_before)
		begin
			pass_count++;
			$display("Test %s passed", name);
		end
		else
		begin
			fail_count++;
			$display("Test %s failed with %0d errors", name, error_count - errors_before);
		end
		got_chan.delete();
		got_data.delete();
		exp_chan.delete();
		exp_data.delete();
	endtask

	task automatic single_frame_a();
		expect_byte(0, 8'ha5);
		send_frame(0, 8'ha5, 1'b0);
		check_result("single frame on rx_a", 1'b0);
	endtask

	task automatic single_frame_b();
		expect_byte(1, 8'h3e);
		send_frame(1, 8'h3e, 1'b0);
		check_result("single frame on rx_b", 1'b0);
	endtask

	// Same start edge on both lines so channel 0 must win the tie
	task automatic simultaneous_frames();
		expect_byte(0, 8'h81);
		expect_byte(1, 8'h7c);
		fork
			send_frame(0, 8'h81, 1'b0);
			send_frame(1, 8'h7c, 1'b0);
		join
		check_result("simultaneous frames", 1'b0);
	endtask

	// Dropped frame followed by a good one on the same line
	task automatic bad_stop_recovery();
		send_frame(0, 8'h5a, 1'b1);
		expect_byte(0, 8'hc3);
		send_frame(0, 8'hc3, 1'b0);
		check_result("low stop bit", 1'b0);
	endtask

	// Quarter-bit low pulse that the mid-bit check rejects
	task automatic start_glitch_recovery();
		send_glitch(1, `UART_CLKS_PER_BIT / 4);
		expect_byte(1, 8'h96);
		send_frame(1, 8'h96, 1'b0);
		check_result("short start pulse", 1'b0);
	endtask

	// Back-to-back random streams with line b shifted by a random offset
	task automatic random_streams();
		uart_pkg::rx_byte_t bytes_a[STREAM_LEN];
		uart_pkg::rx_byte_t bytes_b[STREAM_LEN];
		int offset;
		for (int i = 0; i < STREAM_LEN; i++)
		begin
			bytes_a[i] = uart_pkg::rx_byte_t'(rand_bits(`UART_DATA_LEN));
			expect_byte(0, bytes_a[i]);
		end
		for (int i = 0; i < STREAM_LEN; i++)
		begin
			bytes_b[i] = uart_pkg::rx_byte_t'(rand_bits(`UART_DATA_LEN));
			expect_byte(1, bytes_b[i]);
		end
		offset = rand_bits(6);
		fork
			begin
				for (int i = 0; i < STREAM_LEN; i++)
				begin
					send_frame(0, bytes_a[i], 1'b0);
				end
			end
			begin
				repeat (offset) @(posedge clk);
				for (int i = 0; i < STREAM_LEN; i++)
				begin
					send_frame(1, bytes_b[i], 1'b0);
				end
			end
		join
		check_result("random streams", 1'b1);
	endtask

	initial
	begin
		// Lines idle high while reset is held for five cycles
		reset = 1'b1;
		rx_a = 1'b1;
		rx_b = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		single_frame_a();
		single_frame_b();
		simultaneous_frames();
		bad_stop_recovery();
		start_glitch_recovery();
		random_streams();

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			pass_count, fail_count, error_count);
		if (fail_count == 0 && error_count == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== uart_rx/uart_rx.sv ====
// ------------------------------
// Serial receiver for one line
// Start bit, data bits LSB first,
// one stop bit, no parity
// ------------------------------
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx #(
	parameter int DATA_LEN     = `UART_DATA_LEN,
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              rx_data,
	output logic              receive_sig,
	output uart_pkg::rx_byte_t data
);

	// Counter widths of at least one bit each
	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int BIT_W = (DATA_LEN > 1) ? $clog2(DATA_LEN) : 1;

	// Clock count at which the start bit is checked (mid-bit)
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
	// Clock count at which data and stop bits are sampled
	localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
	// Index of the last data bit
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_LEN - 1);

	// Frame state encoding
	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_START_BIT = 3'd1;
	localparam logic [2:0] S_DATA_BITS = 3'd2;
	localparam logic [2:0] S_STOP_BIT  = 3'd3;
	localparam logic [2:0] S_FINISH    = 3'd4;

	logic [2:0]       state;
	logic [CNT_W-1:0] clk_count;
	logic [BIT_W-1:0] bit_count;

	// Two-flop synchroniser stages
	logic rx_meta;
	logic rx_sync;

	// High on the cycle a data bit is taken
	logic sample_bit;
	// High on the cycle a good stop bit completes the frame
	logic stop_good;

	// Bits of the frame in progress
	uart_pkg::rx_byte_t shift_reg;

	// Line is asynchronous to clk, so bring it in through two flops
	// Both stages reset to the idle-high level of the line
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_data;
			rx_sync <= rx_meta;
		end
	end

	// Data bit is taken at the end of each full bit period
	assign sample_bit = (state == S_DATA_BITS) && (clk_count == LAST_CLK);
	// Stop bit sampled high at the end of its period
	assign stop_good = (state == S_STOP_BIT) && (clk_count == LAST_CLK) && rx_sync;

	// Frame state machine with its clock and bit counters
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state       <= S_IDLE;
			clk_count   <= '0;
			bit_count   <= '0;
			receive_sig <= 1'b0;
		end
		else
		begin
			// Strobe is a single cycle unless set below
			receive_sig <= 1'b0;

			case (state)
				// Wait for the falling edge of a start bit
				S_IDLE:
				begin
					clk_count <= '0;
					if (!rx_sync)
					begin
						state <= S_START_BIT;
					end
				end

				// Wait half a bit, then make sure the line is still low
				S_START_BIT:
				begin
					if (clk_count < HALF_BIT)
					begin
						clk_count <= clk_count + 1'b1;
					end
					else
					begin
						clk_count <= '0;
						bit_count <= '0;
						// A short low pulse is a glitch, not a start bit
						if (!rx_sync)
						begin
							state <= S_DATA_BITS;
						end
						else
						begin
							state <= S_IDLE;
						end
					end
				end

				// One sample per bit period, counted from mid start bit
				S_DATA_BITS:
				begin
					if (clk_count < LAST_CLK)
					begin
						clk_count <= clk_count + 1'b1;
					end
					else
					begin
						clk_count <= '0;
						if (bit_count < LAST_BIT)
						begin
							bit_count <= bit_count + 1'b1;
						end
						else
						begin
							bit_count <= '0;
							state     <= S_STOP_BIT;
						end
					end
				end

				// Stop bit must be high for the byte to be reported
				S_STOP_BIT:
				begin
					if (clk_count < LAST_CLK)
					begin
						clk_count <= clk_count + 1'b1;
					end
					else
					begin
						clk_count <= '0;
						if (rx_sync)
						begin
							receive_sig <= 1'b1;
							state       <= S_FINISH;
						end
						else
						begin
							// Framing error drops the frame without a strobe
							state <= S_IDLE;
						end
					end
				end

				// One cycle here before looking for the next start bit
				S_FINISH:
				begin
					state <= S_IDLE;
				end

				default:
				begin
					state     <= S_IDLE;
					clk_count <= '0;
					bit_count <= '0;
				end
			endcase
		end
	end

	// Data bits collect one per sample starting with the LSB
	// The output byte changes only when a frame ends with a good stop bit
	always_ff @(posedge clk)
	begin
		if (sample_bit)
		begin
			shift_reg[bit_count] <= rx_sync;
		end
		if (stop_good)
		begin
			data <= shift_reg;
		end
	end

endmodule
